// ==== pix_pkg.sv ====
`default_nettype none

package pix_pkg;

  // one colour channel, also the grey value
  localparam int pix_w = 8;

  // signed gradient width, covers -1020 .. 1020
  localparam int grad_w = 11;

  // edge magnitude clips here
  localparam int mag_max = 255;

  // sobel weight on the middle tap of each row or column
  localparam int kern_mid = 2;

  typedef logic [pix_w-1:0] pix_t;

  typedef struct packed {
    pix_t r;
    pix_t g;
    pix_t b;
  } rgb_t;

  // [row][col], row 0 is top, col 0 is left
  typedef pix_t [0:2][0:2] win_t;

  typedef struct packed {
    rgb_t rgb;
    pix_t grey;
    logic edge_mode;
  } dec_t;

  typedef struct packed {
    win_t win;
    rgb_t rgb;
    logic edge_mode;
  } win_beat_t;

  typedef struct packed {
    pix_t edge_val;
    rgb_t rgb;
    logic edge_mode;
  } res_t;

endpackage

`default_nettype wire

// ==== frame_pkg.sv ====
`default_nettype none

package frame_pkg;

  // small frame, keeps simulation short
  localparam int frame_cols = 16;
  localparam int frame_rows = 8;

  // counters only hold in-frame positions
  localparam int col_w = (frame_cols > 1) ? $clog2(frame_cols) : 1;
  localparam int row_w = (frame_rows > 1) ? $clog2(frame_rows) : 1;

endpackage

`default_nettype wire

// ==== pix_stream_if.sv ====
`default_nettype none

// valid/ready stream, one beat moves when both are high
interface pix_stream_if #(
  parameter type payload_t = logic
);

  logic     valid;
  logic     ready;
  // first beat of a frame
  logic     sof;
  payload_t data;

  modport src (
    output valid,
    output sof,
    output data,
    input  ready
  );

  modport snk (
    input  valid,
    input  sof,
    input  data,
    output ready
  );

endinterface

`default_nettype wire

// ==== grey_decode.sv ====
`default_nettype none

module grey_decode (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          edge_en,
  input  logic          in_valid,
  input  logic          in_sof,
  input  pix_pkg::rgb_t in_rgb,
  output logic          in_ready,
  pix_stream_if.src     dec
);

  logic                       accept;
  logic                       frame_mode;
  logic                       beat_mode;
  logic [pix_pkg::pix_w+1:0] grey_sum;

  // output slot free or being emptied this cycle
  assign in_ready = !dec.valid || dec.ready;
  assign accept   = in_valid && in_ready;

  // sof beat takes the live enable, the rest of the frame the latched one
  assign beat_mode = in_sof ? edge_en : frame_mode;

  // r + 2g + b, divided by 4 below
  assign grey_sum = (pix_pkg::pix_w + 2)'(in_rgb.r)
                  + ((pix_pkg::pix_w + 2)'(in_rgb.g) << 1)
                  + (pix_pkg::pix_w + 2)'(in_rgb.b);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dec.valid  <= 1'b0;
      frame_mode <= 1'b0;
    end else begin
      if (in_ready) begin
        dec.valid <= in_valid;
      end
      if (accept && in_sof) begin
        frame_mode <= edge_en;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      dec.sof            <= in_sof;
      dec.data.rgb       <= in_rgb;
      dec.data.grey      <= grey_sum[pix_pkg::pix_w+1:2];
      dec.data.edge_mode <= beat_mode;
    end
  end

endmodule

`default_nettype wire

// ==== line_window.sv ====
`default_nettype none

module line_window (
  input  logic      clk,
  input  logic      rst_n,
  pix_stream_if.snk dec,
  pix_stream_if.src win
);

  // stream takes input, flush and tail are generated zero beats
  typedef enum logic [1:0] {
    st_stream,
    st_flush,
    st_tail
  } state_t;

  state_t                      state;
  logic [frame_pkg::col_w-1:0] col;
  logic [frame_pkg::row_w-1:0] row;

  // lb_a holds the row above, lb_b the row above that
  pix_pkg::pix_t lb_a [frame_pkg::frame_cols];
  pix_pkg::pix_t lb_b [frame_pkg::frame_cols];
  // rgb delay of one row plus one pixel, lines up with the centre
  pix_pkg::rgb_t rgb_line [frame_pkg::frame_cols];
  pix_pkg::rgb_t rgb_d;

  // raw column shift register and the padded window sent out
  pix_pkg::win_t       w;
  pix_pkg::win_t       nw;
  pix_pkg::pix_t [0:2] v;

  logic streaming;
  logic adv_ok;
  logic fire;
  logic beat_edge;
  logic emit;
  logic last_col;
  logic last_row;

  assign streaming = (state == st_stream);
  assign adv_ok    = !win.valid || win.ready;
  assign dec.ready = adv_ok && streaming;
  assign fire      = adv_ok && (dec.valid || !streaming);
  assign beat_edge = !streaming || dec.data.edge_mode;
  assign last_col  = (col == frame_pkg::col_w'(frame_pkg::frame_cols - 1));
  assign last_row  = (row == frame_pkg::row_w'(frame_pkg::frame_rows - 1));

  // nothing to emit until row 0 is complete and pixel (1,0) is in
  assign emit = !beat_edge || !streaming || (row > 1) || (row == 1 && col != 0);

  always_comb begin
    // new column, rows above the frame read as zero
    v[0] = (!streaming || row >= 2) ? lb_b[col] : '0;
    v[1] = (!streaming || row >= 1) ? lb_a[col] : '0;
    v[2] = streaming ? dec.data.grey : '0;
    for (int i = 0; i < 3; i++) begin
      // col 1: left neighbour of column 0 is off the frame
      nw[i][0] = (col == 1) ? '0 : w[i][1];
      nw[i][1] = w[i][2];
      // col 0: centre is the last pixel of a row, right side is padding
      nw[i][2] = (col == 0) ? '0 : v[i];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= st_stream;
      row       <= '0;
      col       <= '0;
      win.valid <= 1'b0;
    end else begin
      if (adv_ok) begin
        win.valid <= fire && emit;
      end
      if (fire) begin
        case (state)
          st_stream: begin
            if (last_col) begin
              col <= '0;
              if (last_row) begin
                row <= '0;
                if (dec.data.edge_mode) begin
                  state <= st_flush;
                end
              end else begin
                row <= row + 1'b1;
              end
            end else begin
              col <= col + 1'b1;
            end
          end
          st_flush: begin
            if (last_col) begin
              col   <= '0;
              state <= st_tail;
            end else begin
              col <= col + 1'b1;
            end
          end
          default: begin
            state <= st_stream;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      lb_b[col]     <= lb_a[col];
      lb_a[col]     <= v[2];
      rgb_line[col] <= streaming ? dec.data.rgb : '0;
      rgb_d         <= rgb_line[col];
      for (int i = 0; i < 3; i++) begin
        w[i][0] <= w[i][1];
        w[i][1] <= w[i][2];
        w[i][2] <= v[i];
      end
      // in edge mode the first window out is centred on (0,0)
      win.sof            <= beat_edge ? (streaming && row == 1 && col == 1) : dec.sof;
      win.data.win       <= beat_edge ? nw : '0;
      win.data.rgb       <= beat_edge ? rgb_d : dec.data.rgb;
      win.data.edge_mode <= beat_edge;
    end
  end

  a_sof_origin: assert property (@(posedge clk) disable iff (!rst_n)
    dec.valid && dec.ready && dec.sof |-> row == '0 && col == '0);

  a_win_hold: assert property (@(posedge clk) disable iff (!rst_n)
    win.valid && !win.ready |=> win.valid && $stable(win.data));

endmodule

`default_nettype wire

// ==== sobel_execute.sv ====
`default_nettype none

module sobel_execute (
  input  logic      clk,
  input  logic      rst_n,
  pix_stream_if.snk win,
  pix_stream_if.src res
);

  logic                                s1_valid;
  logic                                s1_sof;
  logic                                s1_mode;
  pix_pkg::rgb_t                       s1_rgb;
  logic signed [pix_pkg::grad_w-1:0]   s1_gx;
  logic signed [pix_pkg::grad_w-1:0]   s1_gy;
  logic signed [pix_pkg::grad_w-1:0]   gx;
  logic signed [pix_pkg::grad_w-1:0]   gy;
  logic [pix_pkg::grad_w-1:0]          abs_x;
  logic [pix_pkg::grad_w-1:0]          abs_y;
  logic [pix_pkg::grad_w:0]            mag_sum;
  logic                                adv1;
  logic                                adv2;

  // a + 2b + c, one side of the kernel
  function automatic logic [pix_pkg::grad_w-1:0] tri_sum(
    input pix_pkg::pix_t a,
    input pix_pkg::pix_t b,
    input pix_pkg::pix_t c
  );
    tri_sum = (pix_pkg::grad_w)'(a)
            + (pix_pkg::grad_w)'(pix_pkg::kern_mid * b)
            + (pix_pkg::grad_w)'(c);
  endfunction

  assign adv2      = !res.valid || res.ready;
  assign adv1      = !s1_valid || adv2;
  assign win.ready = adv1;

  // right minus left, bottom minus top
  assign gx = $signed(tri_sum(win.data.win[0][2], win.data.win[1][2], win.data.win[2][2]))
            - $signed(tri_sum(win.data.win[0][0], win.data.win[1][0], win.data.win[2][0]));
  assign gy = $signed(tri_sum(win.data.win[2][0], win.data.win[2][1], win.data.win[2][2]))
            - $signed(tri_sum(win.data.win[0][0], win.data.win[0][1], win.data.win[0][2]));

  assign abs_x   = s1_gx[pix_pkg::grad_w-1] ? -s1_gx : s1_gx;
  assign abs_y   = s1_gy[pix_pkg::grad_w-1] ? -s1_gy : s1_gy;
  assign mag_sum = {1'b0, abs_x} + {1'b0, abs_y};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      res.valid <= 1'b0;
    end else begin
      if (adv1) begin
        s1_valid <= win.valid;
      end
      if (adv2) begin
        res.valid <= s1_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (adv1 && win.valid) begin
      s1_gx   <= gx;
      s1_gy   <= gy;
      s1_rgb  <= win.data.rgb;
      s1_mode <= win.data.edge_mode;
      s1_sof  <= win.sof;
    end
    if (adv2 && s1_valid) begin
      res.data.edge_val  <= (mag_sum > pix_pkg::mag_max) ?
                            pix_pkg::pix_t'(pix_pkg::mag_max) :
                            mag_sum[pix_pkg::pix_w-1:0];
      res.data.rgb       <= s1_rgb;
      res.data.edge_mode <= s1_mode;
      res.sof            <= s1_sof;
    end
  end

  // each gradient is at most four full-scale pixels in size
  a_grad_range: assert property (@(posedge clk) disable iff (!rst_n)
    s1_valid |-> abs_x <= 4 * pix_pkg::mag_max && abs_y <= 4 * pix_pkg::mag_max);

endmodule

`default_nettype wire

// ==== edge_result.sv ====
`default_nettype none

module edge_result (
  input  logic          clk,
  input  logic          rst_n,
  pix_stream_if.snk     res,
  output logic          out_valid,
  output logic          out_sof,
  output pix_pkg::rgb_t out_rgb,
  input  logic          out_ready
);

  pix_pkg::rgb_t pick;

  assign res.ready = !out_valid || out_ready;

  // edge value on all three channels, or the original pixel
  always_comb begin
    if (res.data.edge_mode) begin
      pick.r = res.data.edge_val;
      pick.g = res.data.edge_val;
      pick.b = res.data.edge_val;
    end else begin
      pick = res.data.rgb;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (res.ready) begin
      out_valid <= res.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (res.ready && res.valid) begin
      out_sof <= res.sof;
      out_rgb <= pick;
    end
  end

  a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_rgb) && $stable(out_sof));

endmodule

`default_nettype wire

// ==== edge_top.sv ====
`default_nettype none

module edge_top (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          edge_en,
  input  logic          in_valid,
  input  logic          in_sof,
  input  pix_pkg::pix_t in_r,
  input  pix_pkg::pix_t in_g,
  input  pix_pkg::pix_t in_b,
  output logic          in_ready,
  output logic          out_valid,
  output logic          out_sof,
  output pix_pkg::pix_t out_r,
  output pix_pkg::pix_t out_g,
  output pix_pkg::pix_t out_b,
  input  logic          out_ready
);

  pix_pkg::rgb_t in_rgb;
  pix_pkg::rgb_t out_rgb;

  pix_stream_if #(.payload_t(pix_pkg::dec_t))      dec_s ();
  pix_stream_if #(.payload_t(pix_pkg::win_beat_t)) win_s ();
  pix_stream_if #(.payload_t(pix_pkg::res_t))      res_s ();

  assign in_rgb.r = in_r;
  assign in_rgb.g = in_g;
  assign in_rgb.b = in_b;

  assign out_r = out_rgb.r;
  assign out_g = out_rgb.g;
  assign out_b = out_rgb.b;

  grey_decode u_decode (
    .clk      (clk),
    .rst_n    (rst_n),
    .edge_en  (edge_en),
    .in_valid (in_valid),
    .in_sof   (in_sof),
    .in_rgb   (in_rgb),
    .in_ready (in_ready),
    .dec      (dec_s)
  );

  line_window u_window (
    .clk   (clk),
    .rst_n (rst_n),
    .dec   (dec_s),
    .win   (win_s)
  );

  sobel_execute u_sobel (
    .clk   (clk),
    .rst_n (rst_n),
    .win   (win_s),
    .res   (res_s)
  );

  edge_result u_result (
    .clk       (clk),
    .rst_n     (rst_n),
    .res       (res_s),
    .out_valid (out_valid),
    .out_sof   (out_sof),
    .out_rgb   (out_rgb),
    .out_ready (out_ready)
  );

endmodule

`default_nettype wire

// ==== tb_edge_ref.svh ====
`ifndef tb_edge_ref_svh
`define tb_edge_ref_svh

// fibonacci lfsr, taps 32 22 2 1
logic [31:0] lfsr_state = 32'h8ac3_ec6c;

// frames as sent, {r, g, b} per pixel in raster order
logic [23:0] frame_rgb [n_frames][npix];
logic        frame_edge [n_frames];

function automatic logic next_lfsr_bit();
  logic fb;
  fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
  lfsr_state = {lfsr_state[30:0], fb};
  return fb;
endfunction

// one lfsr step per bit taken
function automatic logic [31:0] random_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], next_lfsr_bit()};
  end
  return v;
endfunction

// grey value with zero outside the frame
function automatic int grey_at(input int f, input int r, input int c);
  logic [23:0] p;
  if (r < 0 || r >= frame_pkg::frame_rows || c < 0 || c >= frame_pkg::frame_cols) begin
    return 0;
  end
  p = frame_rgb[f][r * frame_pkg::frame_cols + c];
  return (int'(p[23:16]) + 2 * int'(p[15:8]) + int'(p[7:0])) / 4;
endfunction

function automatic logic [23:0] expected_pixel(input int f, input int idx);
  int r;
  int c;
  int gx;
  int gy;
  int mag;
  if (!frame_edge[f]) begin
    return frame_rgb[f][idx];
  end
  r = idx / frame_pkg::frame_cols;
  c = idx % frame_pkg::frame_cols;
  // right column minus left column
  gx = grey_at(f, r - 1, c + 1) + 2 * grey_at(f, r, c + 1) + grey_at(f, r + 1, c + 1)
     - grey_at(f, r - 1, c - 1) - 2 * grey_at(f, r, c - 1) - grey_at(f, r + 1, c - 1);
  // bottom row minus top row
  gy = grey_at(f, r + 1, c - 1) + 2 * grey_at(f, r + 1, c) + grey_at(f, r + 1, c + 1)
     - grey_at(f, r - 1, c - 1) - 2 * grey_at(f, r - 1, c) - grey_at(f, r - 1, c + 1);
  mag = (gx < 0 ? -gx : gx) + (gy < 0 ? -gy : gy);
  if (mag > 255) begin
    mag = 255;
  end
  return {3{mag[7:0]}};
endfunction

`endif

// ==== tb_edge_top.sv ====
`default_nettype none

module tb_edge_top;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int npix     = frame_pkg::frame_rows * frame_pkg::frame_cols;
  localparam int n_frames = 6;
  localparam int cycle_limit = 4 * n_frames * npix + 400;

  // per frame: edge mode, flat colour, stalls, edge_en flip halfway
  localparam logic [n_frames-1:0] edge_frames    = 6'b101110;
  localparam logic [n_frames-1:0] uniform_frames = 6'b000100;
  localparam logic [n_frames-1:0] stall_frames   = 6'b111000;
  localparam logic [n_frames-1:0] toggle_frames  = 6'b110000;

  logic          clk;
  logic          rst_n;
  logic          edge_en;
  logic          in_valid;
  logic          in_sof;
  pix_pkg::pix_t in_r;
  pix_pkg::pix_t in_g;
  pix_pkg::pix_t in_b;
  logic          in_ready;
  logic          out_valid;
  logic          out_sof;
  pix_pkg::pix_t out_r;
  pix_pkg::pix_t out_g;
  pix_pkg::pix_t out_b;
  logic          out_ready;

  int errors    = 0;
  int checks    = 0;
  int out_total = 0;
  int cycles    = 0;

  `include "tb_edge_ref.svh"

  edge_top DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .edge_en   (edge_en),
    .in_valid  (in_valid),
    .in_sof    (in_sof),
    .in_r      (in_r),
    .in_g      (in_g),
    .in_b      (in_b),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_sof   (out_sof),
    .out_r     (out_r),
    .out_g     (out_g),
    .out_b     (out_b),
    .out_ready (out_ready)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic make_frame(input int f);
    logic [31:0] flat;
    logic [31:0] pix;
    flat = random_bits(24);
    frame_edge[f] = edge_frames[f];
    for (int i = 0; i < npix; i++) begin
      pix = uniform_frames[f] ? flat : random_bits(24);
      frame_rgb[f][i] = pix[23:0];
    end
  endtask

  task automatic report_counts();
    $display("checks: %0d  errors: %0d  outputs: %0d of %0d",
             checks, errors, out_total, n_frames * npix);
  endtask

  initial begin : stimulus
    int   idx;
    logic stalls;
    logic moved;
    rst_n     = 1'b0;
    edge_en   = 1'b0;
    in_valid  = 1'b0;
    in_sof    = 1'b0;
    in_r      = '0;
    in_g      = '0;
    in_b      = '0;
    out_ready = 1'b0;
    moved     = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int f = 0; f < n_frames; f++) begin
      make_frame(f);
      stalls = stall_frames[f];
      idx = 0;
      while (idx < npix) begin
        // a pending beat keeps valid high until it is taken
        if (!in_valid || moved) begin
          in_valid = stalls ? (random_bits(2) != 0) : 1'b1;
        end
        in_sof   = (idx == 0);
        {in_r, in_g, in_b} = frame_rgb[f][idx];
        // only the value at sof should count
        edge_en = (toggle_frames[f] && idx >= npix / 2) ? !edge_frames[f] : edge_frames[f];
        out_ready = stalls ? (random_bits(2) != 0) : 1'b1;
        // handshake signals are settled by the falling edge
        @(negedge clk);
        moved = in_valid && in_ready;
        if (moved) begin
          idx++;
        end
        @(posedge clk);
        #1;
      end
    end
    in_valid = 1'b0;
    in_sof   = 1'b0;
    // drain the pipeline, still with stalls
    while (out_total < n_frames * npix) begin
      out_ready = (random_bits(2) != 0);
      @(posedge clk);
      #1;
    end
    out_ready = 1'b1;
    // any extra beat shows up here
    repeat (20) @(posedge clk);
    checks++;
    assert (out_total == n_frames * npix) else begin
      errors++;
      $display("Fail t=%0t out_count: expected %0d got %0d", $time, n_frames * npix, out_total);
    end
    report_counts();
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin : compare
    logic [23:0] got;
    logic [23:0] exp;
    int          fo;
    int          pos;
    int          r;
    int          c;
    fo  = 0;
    pos = 0;
    forever begin
      @(negedge clk);
      if (rst_n && out_valid && out_ready) begin
        got = {out_r, out_g, out_b};
        if (fo >= n_frames) begin
          errors++;
          $display("t=%0t: output beat arrived after the last frame was complete", $time);
        end else begin
          exp = expected_pixel(fo, pos);
          r   = pos / frame_pkg::frame_cols;
          c   = pos % frame_pkg::frame_cols;
          checks++;
          assert (out_sof == (pos == 0)) else begin
            errors++;
            $display("Fail t=%0t out_sof frame %0d pixel %0d: expected %0b got %0b",
                     $time, fo, pos, (pos == 0), out_sof);
          end
          checks++;
          assert (got == exp) else begin
            errors++;
            $display("Fail t=%0t out_rgb frame %0d pixel %0d: expected %06h got %06h",
                     $time, fo, pos, exp, got);
          end
          // flat interior has no gradient
          if (uniform_frames[fo] && edge_frames[fo] && r > 0 && c > 0 &&
              r < frame_pkg::frame_rows - 1 && c < frame_pkg::frame_cols - 1) begin
            checks++;
            assert (got == 24'h0) else begin
              errors++;
              $display("Fail t=%0t out_rgb frame %0d pixel %0d: expected 000000 got %06h",
                       $time, fo, pos, got);
            end
          end
          pos++;
          if (pos == npix) begin
            pos = 0;
            fo++;
          end
        end
        out_total++;
      end
    end
  end

  initial begin : watchdog
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    errors++;
    $display("timeout after %0d cycles, output stream did not complete", cycles);
    report_counts();
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
pix_pkg.sv
frame_pkg.sv
pix_stream_if.sv
grey_decode.sv
line_window.sv
sobel_execute.sv
edge_result.sv
edge_top.sv
tb_edge_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_edge_top
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
